//--- common/rcc_pkg.sv
package rcc_pkg;

  // ----------------------------------------------------------
  // bus and register widths
  // ----------------------------------------------------------
  localparam int APB_ADDR_W  = 12;
  localparam int DATA_W      = 32;
  // number of reset sources latched per core
  localparam int RST_SRC_NUM = 14;

  // register byte offsets
  localparam logic [APB_ADDR_W-1:0] ADDR_C1_RSR = 12'h000;
  localparam logic [APB_ADDR_W-1:0] ADDR_C2_RSR = 12'h004;
  localparam logic [APB_ADDR_W-1:0] ADDR_CSR    = 12'h008;

  // ----------------------------------------------------------
  // status register field positions
  // ----------------------------------------------------------
  // rst_src[13] maps to lpwr2, down to rst_src[0] for obl
  localparam int BIT_LPWR2 = 31;
  localparam int BIT_LPWR1 = 30;
  localparam int BIT_WWDG2 = 29;
  localparam int BIT_WWDG1 = 28;
  localparam int BIT_IWDG2 = 27;
  localparam int BIT_IWDG1 = 26;
  localparam int BIT_SFT2  = 25;
  localparam int BIT_SFT1  = 24;
  localparam int BIT_POR   = 23;
  localparam int BIT_PIN   = 22;
  localparam int BIT_BOR   = 21;
  localparam int BIT_D2    = 20;
  localparam int BIT_D1    = 19;
  // bit 18 reserved, reads 0
  localparam int BIT_OBL   = 17;
  localparam int BIT_RMVF  = 16;

  // csr fields
  localparam int BIT_LSIRDY = 1;
  localparam int BIT_LSION  = 0;

  // por, pin, bor, d2 and d1 come up set
  localparam logic [RST_SRC_NUM-1:0] RSR_RESET_VAL = 14'h003e;
  // power-on source slot in rst_src
  localparam int SRC_POR_IDX = 5;

  // ----------------------------------------------------------
  // enums
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } apb_state_t;

  // register opcode on the internal bus
  typedef enum logic [1:0] {
    SEL_C1_RSR,
    SEL_C2_RSR,
    SEL_CSR,
    SEL_NONE
  } reg_sel_t;

endpackage

//--- common/rcc_reg_bus_if.sv
`timescale 1ns/1ps

// internal register access between apb fsm and register file
interface rcc_reg_bus_if;

  // target register, held for the whole transfer
  rcc_pkg::reg_sel_t           sel;
  // single-cycle write strobe
  logic                        wr;
  logic [rcc_pkg::DATA_W-1:0]  wdata;
  // combinational read word for sel
  logic [rcc_pkg::DATA_W-1:0]  rdata;

  // apb side
  modport fsm (
    output sel,
    output wr,
    output wdata,
    input  rdata
  );

  // register file side
  modport regs (
    input  sel,
    input  wr,
    input  wdata,
    output rdata
  );

endinterface

//--- design/rcc_apb_fsm.sv
`timescale 1ns/1ps

module rcc_apb_fsm (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [rcc_pkg::APB_ADDR_W-1:0]  paddr,
  input  logic [rcc_pkg::DATA_W-1:0]      pwdata,
  output logic [rcc_pkg::DATA_W-1:0]      prdata,
  output logic                            pready,
  output logic                            pslverr,
  rcc_reg_bus_if.fsm                      bus
);

  rcc_pkg::apb_state_t state;
  rcc_pkg::reg_sel_t   sel_q;

  // address map with full compare so holes fall to SEL_NONE
  function automatic rcc_pkg::reg_sel_t decode_addr(
    input logic [rcc_pkg::APB_ADDR_W-1:0] addr
  );
    case (addr)
      rcc_pkg::ADDR_C1_RSR: decode_addr = rcc_pkg::SEL_C1_RSR;
      rcc_pkg::ADDR_C2_RSR: decode_addr = rcc_pkg::SEL_C2_RSR;
      rcc_pkg::ADDR_CSR:    decode_addr = rcc_pkg::SEL_CSR;
      default:              decode_addr = rcc_pkg::SEL_NONE;
    endcase
  endfunction

  // ----------------------------------------------------------
  // state machine
  // ----------------------------------------------------------
  // idle waits for a setup cycle and latches the decoded select
  // setup is the first access cycle and the one wait state
  // access is the second access cycle with pready high
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= rcc_pkg::ST_IDLE;
      sel_q <= rcc_pkg::SEL_NONE;
    end else begin
      case (state)
        rcc_pkg::ST_IDLE: begin
          if (psel && !penable) begin
            sel_q <= decode_addr(paddr);
            state <= rcc_pkg::ST_SETUP;
          end
        end
        rcc_pkg::ST_SETUP: begin
          // penable must follow the setup cycle
          if (psel && penable) begin
            state <= rcc_pkg::ST_ACCESS;
          end else begin
            state <= rcc_pkg::ST_IDLE;
          end
        end
        rcc_pkg::ST_ACCESS: begin
          state <= rcc_pkg::ST_IDLE;
        end
        default: begin
          state <= rcc_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // read word sampled in the wait cycle and valid with pready
  always_ff @(posedge clk) begin
    if (state == rcc_pkg::ST_SETUP) begin
      prdata <= pwrite ? '0 : bus.rdata;
    end
  end

  // ----------------------------------------------------------
  // outputs
  // ----------------------------------------------------------
  assign pready    = (state == rcc_pkg::ST_ACCESS);
  // unmapped offset gives an error on completion
  assign pslverr   = pready && (sel_q == rcc_pkg::SEL_NONE);

  assign bus.sel   = sel_q;
  // register file updates at the edge closing the pready cycle
  assign bus.wr    = pready && pwrite;
  assign bus.wdata = pwdata;

  // ----------------------------------------------------------
  // protocol checks
  // ----------------------------------------------------------
  // master still in the access phase when pready rises
  a_pready_wait : assert property (
    @(posedge clk) disable iff (reset)
    pready |-> psel && penable
  );

  // error completion returns zero read data
  a_pslverr_ready : assert property (
    @(posedge clk) disable iff (reset)
    pslverr |-> pready && (prdata == '0)
  );

  // write strobe only for a transfer that was a write since its setup cycle
  a_wr_strobe : assert property (
    @(posedge clk) disable iff (reset)
    bus.wr |-> pready && $past(pwrite, 2)
  );

endmodule

//--- reset_flags/rcc_rsr_core.sv
`timescale 1ns/1ps

module rcc_rsr_core (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [rcc_pkg::RST_SRC_NUM-1:0]  rst_src,
  input  logic                             rmvf_wr,
  input  logic                             rmvf_wdata,
  output logic [rcc_pkg::RST_SRC_NUM-1:0]  flags,
  output logic                             rmvf
);

  logic [rcc_pkg::RST_SRC_NUM-1:0] flags_nxt;
  // power-on flag alone, for the clear check
  logic [rcc_pkg::RST_SRC_NUM-1:0] por_only;

  // ----------------------------------------------------------
  // flag next state
  // ----------------------------------------------------------
  always_comb begin
    for (int i = 0; i < rcc_pkg::RST_SRC_NUM; i++) begin
      if (i == rcc_pkg::SRC_POR_IDX) begin
        // power-on set wins over rmvf clear
        if (rst_src[i]) begin
          flags_nxt[i] = 1'b1;
        end else if (rmvf) begin
          flags_nxt[i] = 1'b0;
        end else begin
          flags_nxt[i] = flags[i];
        end
      end else begin
        // clear wins, sticky otherwise
        if (rmvf) begin
          flags_nxt[i] = 1'b0;
        end else if (rst_src[i]) begin
          flags_nxt[i] = 1'b1;
        end else begin
          flags_nxt[i] = flags[i];
        end
      end
    end
  end

  // ----------------------------------------------------------
  // flag and rmvf registers
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= rcc_pkg::RSR_RESET_VAL;
      rmvf  <= 1'b0;
    end else begin
      flags <= flags_nxt;
      // plain r/w bit, clear is level driven from here
      if (rmvf_wr) begin
        rmvf <= rmvf_wdata;
      end
    end
  end

  always_comb begin
    por_only = '0;
    por_only[rcc_pkg::SRC_POR_IDX] = flags[rcc_pkg::SRC_POR_IDX];
  end

  // rmvf held with no source active leaves at most the por flag
  a_rmvf_clears : assert property (
    @(posedge clk) disable iff (reset)
    (rmvf && (rst_src == '0)) |=> (flags == por_only)
  );

endmodule

//--- design/rcc_reg_file.sv
`timescale 1ns/1ps

module rcc_reg_file (
  input  logic                             clk,
  input  logic                             reset,
  rcc_reg_bus_if.regs                      bus,
  input  logic [rcc_pkg::RST_SRC_NUM-1:0]  rst_src,
  input  logic                             lsi_rdy,
  output logic                             lsion
);

  logic [rcc_pkg::RST_SRC_NUM-1:0] c1_flags;
  logic [rcc_pkg::RST_SRC_NUM-1:0] c2_flags;
  logic                            c1_rmvf;
  logic                            c2_rmvf;
  logic                            c1_rmvf_wr;
  logic                            c2_rmvf_wr;
  logic [rcc_pkg::DATA_W-1:0]      c1_word;
  logic [rcc_pkg::DATA_W-1:0]      c2_word;
  logic [rcc_pkg::DATA_W-1:0]      csr_word;

  // status word layout, flags read-only
  function automatic logic [rcc_pkg::DATA_W-1:0] pack_rsr(
    input logic [rcc_pkg::RST_SRC_NUM-1:0] f,
    input logic                            rm
  );
    logic [rcc_pkg::DATA_W-1:0] w;
    w = '0;
    w[rcc_pkg::BIT_LPWR2] = f[13];
    w[rcc_pkg::BIT_LPWR1] = f[12];
    w[rcc_pkg::BIT_WWDG2] = f[11];
    w[rcc_pkg::BIT_WWDG1] = f[10];
    w[rcc_pkg::BIT_IWDG2] = f[9];
    w[rcc_pkg::BIT_IWDG1] = f[8];
    w[rcc_pkg::BIT_SFT2]  = f[7];
    w[rcc_pkg::BIT_SFT1]  = f[6];
    w[rcc_pkg::BIT_POR]   = f[rcc_pkg::SRC_POR_IDX];
    w[rcc_pkg::BIT_PIN]   = f[4];
    w[rcc_pkg::BIT_BOR]   = f[3];
    w[rcc_pkg::BIT_D2]    = f[2];
    w[rcc_pkg::BIT_D1]    = f[1];
    w[rcc_pkg::BIT_OBL]   = f[0];
    w[rcc_pkg::BIT_RMVF]  = rm;
    return w;
  endfunction

  // ----------------------------------------------------------
  // per-core status registers
  // ----------------------------------------------------------
  assign c1_rmvf_wr = bus.wr && (bus.sel == rcc_pkg::SEL_C1_RSR);
  assign c2_rmvf_wr = bus.wr && (bus.sel == rcc_pkg::SEL_C2_RSR);

  rcc_rsr_core u_c1_rsr (
    .clk        (clk),
    .reset      (reset),
    .rst_src    (rst_src),
    .rmvf_wr    (c1_rmvf_wr),
    .rmvf_wdata (bus.wdata[rcc_pkg::BIT_RMVF]),
    .flags      (c1_flags),
    .rmvf       (c1_rmvf)
  );

  rcc_rsr_core u_c2_rsr (
    .clk        (clk),
    .reset      (reset),
    .rst_src    (rst_src),
    .rmvf_wr    (c2_rmvf_wr),
    .rmvf_wdata (bus.wdata[rcc_pkg::BIT_RMVF]),
    .flags      (c2_flags),
    .rmvf       (c2_rmvf)
  );

  // ----------------------------------------------------------
  // control/status register
  // ----------------------------------------------------------
  // lsion, only writable bit of the csr
  always_ff @(posedge clk) begin
    if (reset) begin
      lsion <= 1'b0;
    end else if (bus.wr && (bus.sel == rcc_pkg::SEL_CSR)) begin
      lsion <= bus.wdata[rcc_pkg::BIT_LSION];
    end
  end

  always_comb begin
    csr_word = '0;
    // lsirdy straight from the oscillator, no sync stage
    csr_word[rcc_pkg::BIT_LSIRDY] = lsi_rdy;
    csr_word[rcc_pkg::BIT_LSION]  = lsion;
  end

  // ----------------------------------------------------------
  // read mux
  // ----------------------------------------------------------
  assign c1_word = pack_rsr(c1_flags, c1_rmvf);
  assign c2_word = pack_rsr(c2_flags, c2_rmvf);

  always_comb begin
    case (bus.sel)
      rcc_pkg::SEL_C1_RSR: bus.rdata = c1_word;
      rcc_pkg::SEL_C2_RSR: bus.rdata = c2_word;
      rcc_pkg::SEL_CSR:    bus.rdata = csr_word;
      // unmapped reads as zero
      default:             bus.rdata = '0;
    endcase
  end

endmodule

//--- design/rcc_reset_ctrl_top.sv
`timescale 1ns/1ps

module rcc_reset_ctrl_top (
  input  logic                             clk,
  input  logic                             reset,
  // apb slave
  input  logic                             psel,
  input  logic                             penable,
  input  logic                             pwrite,
  input  logic [rcc_pkg::APB_ADDR_W-1:0]   paddr,
  input  logic [rcc_pkg::DATA_W-1:0]       pwdata,
  output logic [rcc_pkg::DATA_W-1:0]       prdata,
  output logic                             pready,
  output logic                             pslverr,
  // reset source pulses, lpwr2 at msb
  input  logic [rcc_pkg::RST_SRC_NUM-1:0]  rst_src,
  // low-speed oscillator
  input  logic                             lsi_rdy,
  output logic                             lsion
);

  // ----------------------------------------------------------
  // internal register bus
  // ----------------------------------------------------------
  rcc_reg_bus_if u_reg_bus ();

  // ----------------------------------------------------------
  // apb front end
  // ----------------------------------------------------------
  rcc_apb_fsm u_apb_fsm (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .bus     (u_reg_bus.fsm)
  );

  // ----------------------------------------------------------
  // status and control registers
  // ----------------------------------------------------------
  rcc_reg_file u_reg_file (
    .clk     (clk),
    .reset   (reset),
    .bus     (u_reg_bus.regs),
    .rst_src (rst_src),
    .lsi_rdy (lsi_rdy),
    .lsion   (lsion)
  );

endmodule

//--- verif/tb_rcc_apb_tasks.svh
`ifndef TB_RCC_APB_TASKS_SVH
`define TB_RCC_APB_TASKS_SVH

// ------------------------------------------------------------
// idle gap source
// ------------------------------------------------------------
// galois lfsr, right shift, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic [31:0] n;
  n = s >> 1;
  if (s[0]) begin
    n = n ^ 32'h8020_0003;
  end
  return n;
endfunction

// one lfsr step per bit taken
task automatic take_random_bits(input int n, output int val);
  int i;
  val = 0;
  for (i = 0; i < n; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    val = (val << 1) | lfsr_state[0];
  end
endtask

// 0 to 3 idle cycles between transfers
task automatic idle_gap();
  int cycles;
  take_random_bits(2, cycles);
  repeat (cycles) @(posedge clk);
endtask

// ------------------------------------------------------------
// apb master
// ------------------------------------------------------------
// setup cycle, then access held until pready
task automatic apb_transfer(
  input  logic                           wr,
  input  logic [rcc_pkg::APB_ADDR_W-1:0] addr,
  input  logic [rcc_pkg::DATA_W-1:0]     wdata,
  output logic [rcc_pkg::DATA_W-1:0]     rdata,
  output logic                           err
);
  int waits;
  @(posedge clk);
  psel    <= 1'b1;
  penable <= 1'b0;
  pwrite  <= wr;
  paddr   <= addr;
  pwdata  <= wdata;
  @(posedge clk);
  penable <= 1'b1;
  // pready looked at mid-cycle, away from the edges
  waits = 0;
  @(negedge clk);
  while (!pready && (waits < PREADY_TIMEOUT)) begin
    waits++;
    @(negedge clk);
  end
  assert (pready) else stop_on_error("pready never rose, APB transfer timed out");
  // exactly one wait state per transfer
  assert (waits == 1) else
    stop_on_error($sformatf("CHECK FAILED wait_states: got %h expected %h", waits, 1));
  rdata = prdata;
  err   = pslverr;
  // transfer ends at this edge
  @(posedge clk);
  psel    <= 1'b0;
  penable <= 1'b0;
  pwrite  <= 1'b0;
endtask

`endif

//--- verif/tb_rcc_reset_ctrl.sv
`timescale 1ns/1ps

module tb_rcc_reset_ctrl;

  localparam int         RESET_CYCLES   = 10;
  localparam int         PREADY_TIMEOUT = 20;
  localparam int         MAX_STEPS      = 64;
  // pattern opcodes
  localparam logic [3:0] OP_WRITE = 4'h1;
  localparam logic [3:0] OP_READ  = 4'h2;
  localparam logic [3:0] OP_EVENT = 4'h3;
  localparam logic [3:0] OP_LSI   = 4'h4;
  localparam logic [3:0] OP_END   = 4'hf;

  logic                            clk;
  logic                            reset;
  logic                            psel;
  logic                            penable;
  logic                            pwrite;
  logic [rcc_pkg::APB_ADDR_W-1:0]  paddr;
  logic [rcc_pkg::DATA_W-1:0]      pwdata;
  logic [rcc_pkg::DATA_W-1:0]      prdata;
  logic                            pready;
  logic                            pslverr;
  logic [rcc_pkg::RST_SRC_NUM-1:0] rst_src;
  logic                            lsi_rdy;
  logic                            lsion;

  logic [31:0] lfsr_state = 32'hf9b4_6e27;
  // six words per step as op addr data rst_src exp_data exp_pslverr
  logic [31:0] pat_mem [0:6*MAX_STEPS-1];
  int          check_count = 0;

  // first error ends the run
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at first error");
  endtask

  `include "tb_rcc_apb_tasks.svh"

  // ------------------------------------------------------------
  // clock and DUT
  // ------------------------------------------------------------
  initial clk = 1'b0;
  always #20 clk = ~clk;

  rcc_reset_ctrl_top rcc_reset_ctrl_top_i (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .rst_src (rst_src),
    .lsi_rdy (lsi_rdy),
    .lsion   (lsion)
  );

  // ------------------------------------------------------------
  // pattern player
  // ------------------------------------------------------------
  initial begin
    logic [rcc_pkg::DATA_W-1:0] rd;
    logic                       er;
    logic [31:0]                op;
    logic [31:0]                exp;
    logic                       err_exp;
    int                         idx;
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    rst_src = '0;
    lsi_rdy = 1'b0;
    $readmemh("verif/rcc_patterns.txt", pat_mem);
    assert (!$isunknown(pat_mem[0])) else
      stop_on_error("pattern file verif/rcc_patterns.txt could not be read");
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    idx = 0;
    while ((idx < MAX_STEPS) && (pat_mem[idx*6] !== OP_END)) begin
      op      = pat_mem[idx*6];
      exp     = pat_mem[idx*6+4];
      err_exp = pat_mem[idx*6+5][0];
      case (op)
        OP_WRITE: begin
          apb_transfer(1'b1, pat_mem[idx*6+1][rcc_pkg::APB_ADDR_W-1:0],
                       pat_mem[idx*6+2], rd, er);
          // lsion settles at the closing edge
          @(negedge clk);
          assert (er === err_exp) else
            stop_on_error($sformatf("CHECK FAILED pslverr: got %h expected %h", er, err_exp));
          assert (lsion === exp[0]) else
            stop_on_error($sformatf("CHECK FAILED lsion: got %h expected %h", lsion, exp[0]));
          check_count++;
          idle_gap();
        end
        OP_READ: begin
          apb_transfer(1'b0, pat_mem[idx*6+1][rcc_pkg::APB_ADDR_W-1:0],
                       '0, rd, er);
          assert (rd === exp) else
            stop_on_error($sformatf("CHECK FAILED prdata: got %h expected %h", rd, exp));
          assert (er === err_exp) else
            stop_on_error($sformatf("CHECK FAILED pslverr: got %h expected %h", er, err_exp));
          check_count++;
          idle_gap();
        end
        OP_EVENT: begin
          // level held until the next event step
          @(posedge clk);
          rst_src <= pat_mem[idx*6+3][rcc_pkg::RST_SRC_NUM-1:0];
        end
        OP_LSI: begin
          @(posedge clk);
          lsi_rdy <= pat_mem[idx*6+2][0];
        end
        default: begin
          stop_on_error($sformatf("unknown opcode %h at pattern step %0d", op, idx));
        end
      endcase
      idx++;
    end
    assert (idx < MAX_STEPS) else stop_on_error("pattern file has no end marker");
    if (check_count > 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      stop_on_error("pattern file held no checks");
    end
  end

endmodule

//--- list.f
+incdir+verif
common/rcc_pkg.sv
common/rcc_reg_bus_if.sv
design/rcc_apb_fsm.sv
reset_flags/rcc_rsr_core.sv
design/rcc_reg_file.sv
design/rcc_reset_ctrl_top.sv
verif/tb_rcc_reset_ctrl.sv

//--- verif/rcc_patterns.txt
// columns: op addr data rst_src exp_data exp_pslverr, all hex
// op 1 write (exp_data bit 0 = lsion after), 2 read, 3 event (rst_src held), 4 lsi, f end
// state after reset
2 000 00000000 0000 00F80000 0
2 004 00000000 0000 00F80000 0
2 008 00000000 0000 00000000 0
// lpwr1 iwdg1 obl pulse, then sft2 pulse
3 000 00000000 1101 00000000 0
3 000 00000000 0000 00000000 0
2 000 00000000 0000 44FA0000 0
2 004 00000000 0000 44FA0000 0
3 000 00000000 0080 00000000 0
3 000 00000000 0000 00000000 0
2 000 00000000 0000 46FA0000 0
2 004 00000000 0000 46FA0000 0
// rmvf on core 1, flag bits in wdata ignored
1 000 FFFFFFFF 0000 00000000 0
2 000 00000000 0000 00010000 0
2 004 00000000 0000 46FA0000 0
// por and pin held while rmvf set
3 000 00000000 0030 00000000 0
2 000 00000000 0000 00810000 0
2 004 00000000 0000 46FA0000 0
3 000 00000000 0000 00000000 0
2 000 00000000 0000 00010000 0
// wwdg2 pulse blocked on core 1 only
3 000 00000000 0800 00000000 0
3 000 00000000 0000 00000000 0
2 000 00000000 0000 00010000 0
2 004 00000000 0000 66FA0000 0
// rmvf back to 0, lpwr2 and d2 pulse
1 000 00000000 0000 00000000 0
3 000 00000000 2004 00000000 0
3 000 00000000 0000 00000000 0
2 000 00000000 0000 80100000 0
2 004 00000000 0000 E6FA0000 0
// lsion write, lsirdy follows lsi_rdy
1 008 00000001 0000 00000001 0
2 008 00000000 0000 00000001 0
4 000 00000001 0000 00000000 0
2 008 00000000 0000 00000003 0
4 000 00000000 0000 00000000 0
2 008 00000000 0000 00000001 0
// unmapped offset 0x0c
1 00C FFFFFFFF 0000 00000001 1
2 00C 00000000 0000 00000000 1
2 000 00000000 0000 80100000 0
2 004 00000000 0000 E6FA0000 0
2 008 00000000 0000 00000001 0
F 000 00000000 0000 00000000 0
